// File: include/portal_params.svh
`ifndef PORTAL_PARAMS_SVH
`define PORTAL_PARAMS_SVH

`define DATA_W 32
`define ADDR_W 32
`define ID_W 6
`define LEN_W 4
`define OFS_W 5
`define CNT_W 5

// Window address fields
`define PORTAL_SEL_BIT 12
`define PAGE_LO 5
`define PAGE_HI 11

// Control page
`define OFS_INTR_STATUS 5'h00
`define OFS_INTR_ENABLE 5'h04
`define OFS_NUM_TILES 5'h08
`define OFS_QUEUE_STATUS 5'h0C
`define OFS_PORTAL_ID 5'h10
`define OFS_NUM_PORTALS 5'h14

// Data page
`define OFS_MSG_DATA 5'h00
`define OFS_MSG_READY 5'h04

`define REQ_PORTAL_ID 32'd5
`define IND_PORTAL_ID 32'd6
`define NUM_TILES 32'd1
`define NUM_PORTALS 32'd2
`define CTRL_DEFAULT 32'h005A05A0

`define ECHO_DEPTH 4

`endif

// File: verilog/portalPkg.sv
`default_nettype none

`include "portal_params.svh"

package portalPkg;

  // Address bit 12 picks the portal
  typedef enum logic {
    REQ_PORTAL = 1'b0,
    IND_PORTAL = 1'b1
  } portalSelT;

  typedef logic [`OFS_W-1:0] offsetT;  // Byte offset inside a page
  typedef logic [`CNT_W-1:0] countT;

  typedef enum logic {
    BURST_IDLE,
    BURST_ACTIVE
  } burstStateT;

endpackage

`default_nettype wire

// File: verilog/axiPkg.sv
`default_nettype none

`include "portal_params.svh"

package axiPkg;

  typedef logic [`DATA_W-1:0] dataT;
  typedef logic [`ADDR_W-1:0] addrT;
  typedef logic [`ID_W-1:0] idT;
  typedef logic [`LEN_W-1:0] lenT;  // Beats minus one

  // Shared by AR and AW
  typedef struct packed {
    addrT addr;
    lenT len;
    idT id;
  } addrReqT;

  // One word of a burst, portal selection travels with it
  typedef struct packed {
    portalPkg::portalSelT sel;
    logic ctrlPage;
    portalPkg::offsetT offset;
    idT id;
    logic last;
  } beatT;

  typedef struct packed {
    dataT data;
    idT id;
    logic last;
  } readResultT;

  typedef idT writeRespT;

endpackage

`default_nettype wire

// File: verilog/burstDecode.sv
`timescale 1ns/1ns
`default_nettype none

`include "portal_params.svh"

module burstDecode (
  input wire CLK,
  input wire RST_N,
  input wire axiPkg::addrReqT req,
  input wire reqValid,
  output logic reqReady,
  output axiPkg::beatT beat,
  output logic beatValid,
  input wire beatReady
);

  portalPkg::burstStateT state;
  portalPkg::offsetT offset;
  portalPkg::countT remaining;  // Beats still to send
  portalPkg::portalSelT sel;
  logic ctrlPage;
  axiPkg::idT id;

  logic lastBeat;
  logic accept;
  logic beatTaken;

  assign lastBeat = remaining == portalPkg::countT'(1);
  assign beatValid = state == portalPkg::BURST_ACTIVE;
  assign beatTaken = beatValid && beatReady;

  // Next burst may start as the last beat leaves
  assign reqReady = !beatValid || (beatReady && lastBeat);
  assign accept = reqValid && reqReady;

  assign beat = '{
    sel: sel,
    ctrlPage: ctrlPage,
    offset: offset,
    id: id,
    last: lastBeat
  };

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= portalPkg::BURST_IDLE;
    end else if (accept) begin
      state <= portalPkg::BURST_ACTIVE;
    end else if (beatTaken && lastBeat) begin
      state <= portalPkg::BURST_IDLE;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      offset <= req.addr[`OFS_W-1:0];
      remaining <= portalPkg::countT'(req.len) + 1'b1;
      sel <= portalPkg::portalSelT'(req.addr[`PORTAL_SEL_BIT]);
      ctrlPage <= req.addr[`PAGE_HI:`PAGE_LO] == '0;
      id <= req.id;
    end else if (beatTaken) begin
      offset <= offset + portalPkg::offsetT'(4);  // Wraps inside the page
      remaining <= remaining - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/echoQueue.sv
`timescale 1ns/1ns
`default_nettype none

`include "portal_params.svh"

module echoQueue #(
  parameter int DEPTH = `ECHO_DEPTH
) (
  input wire CLK,
  input wire RST_N,
  input wire push,
  input wire axiPkg::dataT pushData,
  input wire pop,
  output axiPkg::dataT popData,
  output logic notEmpty,
  output logic notFull
);

  localparam int PTR_W = $clog2(DEPTH);

  axiPkg::dataT mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W:0] count;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign popData = mem[rdPtr];
  assign notEmpty = count != '0;
  assign notFull = count != (PTR_W + 1)'(DEPTH);

  always_ff @(posedge CLK) begin
    if (push) mem[wrPtr] <= pushData;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
    end
  end

endmodule

`default_nettype wire

// File: verilog/portalExecute.sv
`timescale 1ns/1ns
`default_nettype none

`include "portal_params.svh"

module portalExecute (
  input wire CLK,
  input wire RST_N,
  input wire axiPkg::beatT readBeat,
  input wire readBeatValid,
  output logic readBeatReady,
  output axiPkg::readResultT readResult,
  output logic readResultValid,
  input wire readResultReady,
  input wire axiPkg::beatT writeBeat,
  input wire writeBeatValid,
  output logic writeBeatReady,
  input wire axiPkg::dataT wData,
  input wire wValid,
  output logic wReady,
  output axiPkg::writeRespT writeResp,
  output logic writeRespValid,
  input wire writeRespReady,
  output logic irq
);

  logic intrEnable;
  logic queueNotEmpty;
  logic queueNotFull;
  axiPkg::dataT queueData;
  logic readMsg;
  logic readOk;
  logic writeMsg;
  logic writeOk;
  logic writeFire;
  logic intrStatus;
  axiPkg::dataT ctrlValue;
  axiPkg::dataT dataValue;

  // Read side
  assign readMsg = readBeat.sel == portalPkg::IND_PORTAL && !readBeat.ctrlPage &&
                   readBeat.offset == `OFS_MSG_DATA;
  assign readOk = !readMsg || queueNotEmpty;  // Hold until an indication is there
  assign readResultValid = readBeatValid && readOk;
  assign readBeatReady = readResultReady && readOk;

  assign intrStatus = readBeat.sel == portalPkg::IND_PORTAL && queueNotEmpty;

  always_comb begin
    case (readBeat.offset)
      `OFS_INTR_STATUS, `OFS_QUEUE_STATUS: ctrlValue = axiPkg::dataT'(intrStatus);
      `OFS_NUM_TILES: ctrlValue = `NUM_TILES;
      `OFS_PORTAL_ID: ctrlValue = (readBeat.sel == portalPkg::IND_PORTAL) ?
                                  `IND_PORTAL_ID : `REQ_PORTAL_ID;
      `OFS_NUM_PORTALS: ctrlValue = `NUM_PORTALS;
      default: ctrlValue = `CTRL_DEFAULT;
    endcase
    if (readMsg) dataValue = queueData;
    else if (readBeat.offset == `OFS_MSG_READY) dataValue = axiPkg::dataT'(queueNotFull);
    else dataValue = '0;
  end

  assign readResult = '{
    data: readBeat.ctrlPage ? ctrlValue : dataValue,
    id: readBeat.id,
    last: readBeat.last
  };

  // Write side, one W word per write beat
  assign writeMsg = writeBeat.sel == portalPkg::REQ_PORTAL && !writeBeat.ctrlPage &&
                    writeBeat.offset == `OFS_MSG_DATA;
  assign writeOk = (!writeMsg || queueNotFull) && (!writeBeat.last || writeRespReady);
  assign writeBeatReady = wValid && writeOk;
  assign wReady = writeBeatValid && writeOk;
  assign writeFire = writeBeatValid && wValid && writeOk;

  assign writeRespValid = writeBeatValid && wValid && writeBeat.last &&
                          (!writeMsg || queueNotFull);
  assign writeResp = writeBeat.id;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      intrEnable <= 1'b0;
    end else if (writeFire && writeBeat.ctrlPage && writeBeat.offset == `OFS_INTR_ENABLE) begin
      intrEnable <= wData[0];
    end
  end

  assign irq = intrEnable && queueNotEmpty;

  // Stands in for the user logic
  echoQueue echo_i (
    .CLK(CLK),
    .RST_N(RST_N),
    .push(writeFire && writeMsg),
    .pushData(wData),
    .pop(readBeatValid && readBeatReady && readMsg),
    .popData(queueData),
    .notEmpty(queueNotEmpty),
    .notFull(queueNotFull)
  );

endmodule

`default_nettype wire

// File: verilog/busResult.sv
`timescale 1ns/1ns
`default_nettype none

module busResult (
  input wire CLK,
  input wire RST_N,
  input wire axiPkg::readResultT readResult,
  input wire readResultValid,
  output logic readResultReady,
  input wire axiPkg::writeRespT writeResp,
  input wire writeRespValid,
  output logic writeRespReady,
  output axiPkg::readResultT r,
  output logic rValid,
  input wire rReady,
  output axiPkg::writeRespT b,
  output logic bValid,
  input wire bReady
);

  axiPkg::readResultT rMem [2];
  logic rHead;
  logic rTail;
  logic [1:0] rCount;
  logic rPush;
  logic rPop;

  axiPkg::writeRespT bMem [2];
  logic bHead;
  logic bTail;
  logic [1:0] bCount;
  logic bPush;
  logic bPop;

  // Read data channel
  assign r = rMem[rHead];
  assign rValid = rCount != 2'd0;
  assign readResultReady = rCount != 2'd2 || rReady;  // Full slot frees as head leaves
  assign rPush = readResultValid && readResultReady;
  assign rPop = rValid && rReady;

  // Write response channel
  assign b = bMem[bHead];
  assign bValid = bCount != 2'd0;
  assign writeRespReady = bCount != 2'd2 || bReady;
  assign bPush = writeRespValid && writeRespReady;
  assign bPop = bValid && bReady;

  always_ff @(posedge CLK) begin
    if (rPush) rMem[rTail] <= readResult;
    if (bPush) bMem[bTail] <= writeResp;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      rHead <= 1'b0;
      rTail <= 1'b0;
      rCount <= 2'd0;
      bHead <= 1'b0;
      bTail <= 1'b0;
      bCount <= 2'd0;
    end else begin
      if (rPush) rTail <= !rTail;
      if (rPop) rHead <= !rHead;
      rCount <= rCount + 2'(rPush) - 2'(rPop);
      if (bPush) bTail <= !bTail;
      if (bPop) bHead <= !bHead;
      bCount <= bCount + 2'(bPush) - 2'(bPop);
    end
  end

endmodule

`default_nettype wire

// File: verilog/portalTop.sv
`timescale 1ns/1ns
`default_nettype none

`include "portal_params.svh"

module portalTop (
  input wire CLK,
  input wire RST_N,
  input wire axiPkg::addrReqT ar,
  input wire arValid,
  output logic arReady,
  output axiPkg::readResultT r,
  output logic rValid,
  input wire rReady,
  input wire axiPkg::addrReqT aw,
  input wire awValid,
  output logic awReady,
  input wire axiPkg::dataT wData,
  input wire wValid,
  output logic wReady,
  output axiPkg::writeRespT b,
  output logic bValid,
  input wire bReady,
  output logic irq
);

  axiPkg::beatT readBeat;
  logic readBeatValid;
  logic readBeatReady;
  axiPkg::beatT writeBeat;
  logic writeBeatValid;
  logic writeBeatReady;
  axiPkg::readResultT readResult;
  logic readResultValid;
  logic readResultReady;
  axiPkg::writeRespT writeResp;
  logic writeRespValid;
  logic writeRespReady;

  burstDecode readDecode_i (
    .CLK(CLK),
    .RST_N(RST_N),
    .req(ar),
    .reqValid(arValid),
    .reqReady(arReady),
    .beat(readBeat),
    .beatValid(readBeatValid),
    .beatReady(readBeatReady)
  );

  burstDecode writeDecode_i (
    .CLK(CLK),
    .RST_N(RST_N),
    .req(aw),
    .reqValid(awValid),
    .reqReady(awReady),
    .beat(writeBeat),
    .beatValid(writeBeatValid),
    .beatReady(writeBeatReady)
  );

  portalExecute execute_i (
    .CLK(CLK),
    .RST_N(RST_N),
    .readBeat(readBeat),
    .readBeatValid(readBeatValid),
    .readBeatReady(readBeatReady),
    .readResult(readResult),
    .readResultValid(readResultValid),
    .readResultReady(readResultReady),
    .writeBeat(writeBeat),
    .writeBeatValid(writeBeatValid),
    .writeBeatReady(writeBeatReady),
    .wData(wData),
    .wValid(wValid),
    .wReady(wReady),
    .writeResp(writeResp),
    .writeRespValid(writeRespValid),
    .writeRespReady(writeRespReady),
    .irq(irq)
  );

  busResult result_i (
    .CLK(CLK),
    .RST_N(RST_N),
    .readResult(readResult),
    .readResultValid(readResultValid),
    .readResultReady(readResultReady),
    .writeResp(writeResp),
    .writeRespValid(writeRespValid),
    .writeRespReady(writeRespReady),
    .r(r),
    .rValid(rValid),
    .rReady(rReady),
    .b(b),
    .bValid(bValid),
    .bReady(bReady)
  );

endmodule

`default_nettype wire

// File: sim/portalTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "portal_params.svh"

module portalTb;

  logic CLK = 1'b0;
  logic RST_N;
  axiPkg::addrReqT ar;
  logic arValid;
  logic arReady;
  axiPkg::readResultT r;
  logic rValid;
  logic rReady;
  axiPkg::addrReqT aw;
  logic awValid;
  logic awReady;
  axiPkg::dataT wData;
  logic wValid;
  logic wReady;
  axiPkg::writeRespT b;
  logic bValid;
  logic bReady;
  logic irq;

  logic [31:0] lfsrState = 32'ha76f5f05;
  logic randomReady = 1'b0;
  logic nextRReady;
  logic nextBReady;
  int beatsIssued = 0;
  int cycles;
  int checkCount = 0;
  int mismatchCount = 0;
  int otherErrors = 0;

  axiPkg::readResultT expR[$];
  axiPkg::writeRespT expB[$];
  axiPkg::readResultT expRead;
  axiPkg::writeRespT expResp;
  axiPkg::dataT modelQueue[$];  // Words the echo queue should hold
  logic modelEnable = 1'b0;
  axiPkg::dataT words [4];
  axiPkg::addrT addrTable [4] = '{32'h008, 32'h1024, 32'h024, 32'h1018};

  portalTop dut_i (
    .CLK(CLK),
    .RST_N(RST_N),
    .ar(ar),
    .arValid(arValid),
    .arReady(arReady),
    .r(r),
    .rValid(rValid),
    .rReady(rReady),
    .aw(aw),
    .awValid(awValid),
    .awReady(awReady),
    .wData(wData),
    .wValid(wValid),
    .wReady(wReady),
    .b(b),
    .bValid(bValid),
    .bReady(bReady),
    .irq(irq)
  );

  always #2 CLK = !CLK;

  function automatic logic lfsrBit();
    logic bitOut;
    bitOut = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (bitOut) lfsrState = lfsrState ^ 32'h80200003;
    return bitOut;
  endfunction

  function automatic logic [31:0] randomBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) value = {value[30:0], lfsrBit()};
    return value;
  endfunction

  // Data a read beat should return per the register map and the model queue
  function automatic axiPkg::dataT expectedRead(input logic isInd, input logic isCtrl,
                                                input portalPkg::offsetT ofs);
    logic notEmpty;
    notEmpty = modelQueue.size() != 0;
    if (isCtrl) begin
      case (ofs)
        `OFS_INTR_STATUS, `OFS_QUEUE_STATUS: return axiPkg::dataT'(isInd && notEmpty);
        `OFS_NUM_TILES: return `NUM_TILES;
        `OFS_PORTAL_ID: return isInd ? `IND_PORTAL_ID : `REQ_PORTAL_ID;
        `OFS_NUM_PORTALS: return `NUM_PORTALS;
        default: return `CTRL_DEFAULT;
      endcase
    end
    if (isInd && ofs == `OFS_MSG_DATA) return modelQueue[0];
    if (ofs == `OFS_MSG_READY) return axiPkg::dataT'(modelQueue.size() < `ECHO_DEPTH);
    return '0;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    checkCount++;
    if (expected !== actual) begin
      mismatchCount++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic readBurst(input axiPkg::addrT addr, input axiPkg::lenT len);
    axiPkg::idT id;
    axiPkg::readResultT exp;
    portalPkg::offsetT ofs;
    logic isInd;
    logic isCtrl;
    id = axiPkg::idT'(randomBits(`ID_W));
    isInd = addr[`PORTAL_SEL_BIT];
    isCtrl = addr[`PAGE_HI:`PAGE_LO] == '0;
    ofs = addr[`OFS_W-1:0];
    for (int i = 0; i <= len; i++) begin
      exp.data = expectedRead(isInd, isCtrl, ofs);
      exp.id = id;
      exp.last = i == len;
      expR.push_back(exp);
      if (isInd && !isCtrl && ofs == `OFS_MSG_DATA) void'(modelQueue.pop_front());
      ofs = ofs + portalPkg::offsetT'(4);
    end
    beatsIssued += len + 1;
    @(posedge CLK);
    #1;
    ar = '{addr: addr, len: len, id: id};
    arValid = 1'b1;
    do @(posedge CLK); while (!arReady);
    #1 arValid = 1'b0;
  endtask

  task automatic writeBurst(input axiPkg::addrT addr, input axiPkg::lenT len,
                            input axiPkg::dataT data [4]);
    axiPkg::idT id;
    portalPkg::offsetT ofs;
    logic isInd;
    logic isCtrl;
    id = axiPkg::idT'(randomBits(`ID_W));
    isInd = addr[`PORTAL_SEL_BIT];
    isCtrl = addr[`PAGE_HI:`PAGE_LO] == '0;
    ofs = addr[`OFS_W-1:0];
    for (int i = 0; i <= len; i++) begin
      if (!isInd && !isCtrl && ofs == `OFS_MSG_DATA) modelQueue.push_back(data[i]);
      if (isCtrl && ofs == `OFS_INTR_ENABLE) modelEnable = data[i][0];
      ofs = ofs + portalPkg::offsetT'(4);
    end
    expB.push_back(id);
    beatsIssued += len + 1;
    @(posedge CLK);
    #1;
    aw = '{addr: addr, len: len, id: id};
    awValid = 1'b1;
    do @(posedge CLK); while (!awReady);
    #1 awValid = 1'b0;
    for (int i = 0; i <= len; i++) begin
      wData = data[i];
      wValid = 1'b1;
      do @(posedge CLK); while (!wReady);
      #1;
    end
    wValid = 1'b0;
  endtask

  task automatic waitIdle();
    while (expR.size() != 0 || expB.size() != 0) @(negedge CLK);
    @(posedge CLK);
  endtask

  // Ready bits drawn between edges, applied after the next rising edge
  always @(negedge CLK) begin
    nextRReady = randomReady ? lfsrBit() : 1'b1;
    nextBReady = randomReady ? lfsrBit() : 1'b1;
    @(posedge CLK);
    #1;
    rReady = nextRReady;
    bReady = nextBReady;
  end

  // Compare each R and B transfer with the oldest expected entry
  always @(posedge CLK) begin
    if (RST_N && rValid && rReady) begin
      if (expR.size() == 0) begin
        otherErrors++;
        $display("Read data returned while no read beat was outstanding");
      end else begin
        expRead = expR.pop_front();
        checkValue("r.data", expRead.data, r.data);
        checkValue("r.id", expRead.id, r.id);
        checkValue("r.last", expRead.last, r.last);
      end
    end
    if (RST_N && bValid && bReady) begin
      if (expB.size() == 0) begin
        otherErrors++;
        $display("Write response returned while no write burst was outstanding");
      end else begin
        expResp = expB.pop_front();
        checkValue("b", expResp, b);
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles <= 16 + 200 * (beatsIssued + 1)) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout: responses still outstanding after %0d cycles", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    RST_N = 1'b0;
    ar = '0;
    arValid = 1'b0;
    aw = '0;
    awValid = 1'b0;
    wData = '0;
    wValid = 1'b0;
    rReady = 1'b1;
    bReady = 1'b1;
    words = '{default: '0};
    repeat (16) @(posedge CLK);
    #1 RST_N = 1'b1;
    @(posedge CLK);
    checkValue("rValid", 0, rValid);
    checkValue("bValid", 0, bValid);
    checkValue("irq", 0, irq);

    // Control pages and the default value
    readBurst(32'h008, 3);
    readBurst(32'h1008, 3);
    readBurst(32'h018, 0);
    waitIdle();

    // Fill the echo queue until MSG_READY drops
    for (int i = 0; i < `ECHO_DEPTH; i++) begin
      readBurst(32'h024, 0);
      waitIdle();
      words[0] = randomBits(32);
      writeBurst(32'h020, 0, words);
      waitIdle();
    end
    readBurst(32'h024, 0);
    waitIdle();

    words[0] = 32'd1;
    writeBurst(32'h004, 0, words);
    waitIdle();
    checkValue("irq", modelEnable && modelQueue.size() != 0, irq);
    readBurst(32'h1000, 0);
    for (int i = 0; i < `ECHO_DEPTH; i++) readBurst(32'h1020, 0);
    readBurst(32'h100C, 0);
    waitIdle();
    checkValue("irq", modelEnable && modelQueue.size() != 0, irq);

    // Only the first beat lands on MSG_DATA
    for (int i = 0; i < 4; i++) words[i] = randomBits(32);
    writeBurst(32'h020, 3, words);
    waitIdle();
    checkValue("irq", modelEnable && modelQueue.size() != 0, irq);
    readBurst(32'h1020, 0);
    readBurst(32'h100C, 0);
    waitIdle();

    randomReady = 1'b1;
    for (int i = 0; i < 8; i++) begin
      readBurst(addrTable[randomBits(2)], axiPkg::lenT'(randomBits(2)));
    end
    words[0] = '0;
    words[1] = randomBits(32);
    writeBurst(32'h004, 0, words);
    writeBurst(32'h1000, 1, words);
    readBurst(32'h1018, 3);
    waitIdle();
    randomReady = 1'b0;
    checkValue("irq", modelEnable && modelQueue.size() != 0, irq);

    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             checkCount, mismatchCount, otherErrors);
    if (mismatchCount == 0 && otherErrors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
verilog/portalPkg.sv
verilog/axiPkg.sv
verilog/burstDecode.sv
verilog/echoQueue.sv
verilog/portalExecute.sv
verilog/busResult.sv
verilog/portalTop.sv
sim/portalTb.sv
